// File: logic/tcdm_pkg.sv
`default_nettype none

package tcdm_pkg;

    // Bus widths
    localparam int unsigned ADDR_W    = 8;
    localparam int unsigned DATA_W    = 32;
    localparam int unsigned META_ID_W = 4;

    // Word count of the bank
    localparam int unsigned MEM_WORDS = 2 ** ADDR_W;

    // Holds either a master's own ID or a remapped slot number
    typedef logic [META_ID_W-1:0] meta_id_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
        meta_id_t          id;
    } tcdm_req_t;

    // Write responses carry zero read data
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              write;
        meta_id_t          id;
    } tcdm_resp_t;

endpackage

`default_nettype wire

// File: logic/remap_pkg.sv
`default_nettype none

package remap_pkg;

    // Core-side masters sharing the bank
    localparam int unsigned NUM_MASTERS  = 4;
    localparam int unsigned MASTER_IDX_W = 2;

    // Outstanding transactions tracked by the remapper
    localparam int unsigned SLOT_DEPTH   = 4;
    localparam int unsigned SLOT_W       = 2;

    // Slot number sent to the bank in place of the master ID
    typedef logic [SLOT_W-1:0] slot_id_t;

    // Index of the master that owns a slot
    typedef logic [MASTER_IDX_W-1:0] master_idx_t;

endpackage

`default_nettype wire

// File: logic/tcdm_rr_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module tcdm_rr_arbiter import tcdm_pkg::*, remap_pkg::*; (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire tcdm_req_t [NUM_MASTERS-1:0]  req_i,
    input  wire logic      [NUM_MASTERS-1:0]  req_valid_i,
    output logic           [NUM_MASTERS-1:0]  req_ready_o,
    output tcdm_req_t                         req_o,
    output logic                              req_valid_o,
    input  wire logic                         gnt_i,
    output master_idx_t                       idx_o
);

    // Search start one past the last winner
    master_idx_t ptr_q;
    logic        lock_q;
    master_idx_t lock_idx_q;
    master_idx_t sel_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic        found;
        master_idx_t cand;
        found   = 1'b0;
        sel_idx = ptr_q;
        for (int k = 0; k < NUM_MASTERS; k++) begin
            cand = ptr_q + master_idx_t'(k);
            if (!found && req_valid_i[cand]) begin
                found   = 1'b1;
                sel_idx = cand;
            end
        end
        // A waiting winner keeps the grant
        if (lock_q) begin
            sel_idx = lock_idx_q;
        end
    end

    assign idx_o       = sel_idx;
    assign req_o       = req_i[sel_idx];
    assign req_valid_o = req_valid_i[sel_idx];

    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            req_ready_o[i] = gnt_i && req_valid_o && (sel_idx == master_idx_t'(i));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointer and lock state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= req_valid_o && !gnt_i;
            lock_idx_q <= sel_idx;
            if (req_valid_o && gnt_i) begin
                ptr_q <= sel_idx + master_idx_t'(1);
            end
        end
    end

    // Held request keeps winner and payload until granted
    a_lock_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_o && !gnt_i |=> req_valid_o && $stable(req_o) && $stable(idx_o));

endmodule

`default_nettype wire

// File: logic/tcdm_slot_table.sv
`default_nettype none
`timescale 1ns/100ps

module tcdm_slot_table import tcdm_pkg::*, remap_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    // Allocation on a bank request transfer
    input  wire logic        take_i,
    input  wire meta_id_t    take_id_i,
    input  wire master_idx_t take_master_i,
    // Release on a response transfer
    input  wire logic        free_i,
    input  wire slot_id_t    free_slot_i,
    output slot_id_t         free_slot_o,
    output logic             full_o,
    output meta_id_t         orig_id_o,
    output master_idx_t      owner_o
);

    logic        [SLOT_DEPTH-1:0] valid_q;
    meta_id_t    [SLOT_DEPTH-1:0] orig_q;
    master_idx_t [SLOT_DEPTH-1:0] owner_q;

    // Lowest free slot, scanned from the top so the lowest index wins
    always_comb begin
        free_slot_o = '0;
        for (int s = SLOT_DEPTH - 1; s >= 0; s--) begin
            if (!valid_q[s]) begin
                free_slot_o = slot_id_t'(s);
            end
        end
    end

    assign full_o    = &valid_q;
    assign orig_id_o = orig_q[free_slot_i];
    assign owner_o   = owner_q[free_slot_i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            if (free_i) begin
                valid_q[free_slot_i] <= 1'b0;
            end
            // Taking after freeing leaves a reused slot taken
            if (take_i) begin
                valid_q[free_slot_o] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_i) begin
            orig_q[free_slot_o]  <= take_id_i;
            owner_q[free_slot_o] <= take_master_i;
        end
    end

    // A response must come back on a slot that is outstanding
    a_free_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        free_i |-> valid_q[free_slot_i]);

endmodule

`default_nettype wire

// File: logic/tcdm_id_remapper.sv
`default_nettype none
`timescale 1ns/100ps

module tcdm_id_remapper import tcdm_pkg::*, remap_pkg::*; (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    // Master side
    input  wire tcdm_req_t  [NUM_MASTERS-1:0] req_i,
    input  wire logic       [NUM_MASTERS-1:0] req_valid_i,
    output logic            [NUM_MASTERS-1:0] req_ready_o,
    output tcdm_resp_t      [NUM_MASTERS-1:0] resp_o,
    output logic            [NUM_MASTERS-1:0] resp_valid_o,
    input  wire logic       [NUM_MASTERS-1:0] resp_ready_i,
    // Bank side
    output tcdm_req_t                         bank_req_o,
    output logic                              bank_req_valid_o,
    input  wire logic                         bank_req_ready_i,
    input  wire tcdm_resp_t                   bank_resp_i,
    input  wire logic                         bank_resp_valid_i,
    output logic                              bank_resp_ready_o
);

    tcdm_req_t   arb_req;
    logic        arb_valid;
    logic        arb_gnt;
    master_idx_t arb_idx;

    slot_id_t    next_slot;
    logic        slots_full;
    meta_id_t    orig_id;
    master_idx_t owner;
    slot_id_t    resp_slot;

    ////////////////////////////////////////////////////////////////////////////
    // Request path
    ////////////////////////////////////////////////////////////////////////////

    tcdm_rr_arbiter i_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_o       (arb_req),
        .req_valid_o (arb_valid),
        .gnt_i       (arb_gnt),
        .idx_o       (arb_idx)
    );

    // Nothing leaves without a free slot
    assign arb_gnt          = bank_req_ready_i && !slots_full;
    assign bank_req_valid_o = arb_valid && !slots_full;

    always_comb begin
        bank_req_o    = arb_req;
        bank_req_o.id = meta_id_t'(next_slot);
    end

    tcdm_slot_table i_slot_table (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .take_i        (bank_req_valid_o && bank_req_ready_i),
        .take_id_i     (arb_req.id),
        .take_master_i (arb_idx),
        .free_i        (bank_resp_valid_i && bank_resp_ready_o),
        .free_slot_i   (resp_slot),
        .free_slot_o   (next_slot),
        .full_o        (slots_full),
        .orig_id_o     (orig_id),
        .owner_o       (owner)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////////////////////

    assign resp_slot         = slot_id_t'(bank_resp_i.id);
    assign bank_resp_ready_o = resp_ready_i[owner];

    // Every master sees the payload, only the owner sees valid
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            resp_o[i]       = bank_resp_i;
            resp_o[i].id    = orig_id;
            resp_valid_o[i] = bank_resp_valid_i && (owner == master_idx_t'(i));
        end
    end

endmodule

`default_nettype wire

// File: logic/tcdm_bank.sv
`default_nettype none
`timescale 1ns/100ps

module tcdm_bank import tcdm_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire tcdm_req_t req_i,
    input  wire logic      req_valid_i,
    output logic           req_ready_o,
    output tcdm_resp_t     resp_o,
    output logic           resp_valid_o,
    input  wire logic      resp_ready_i
);

    logic [DATA_W-1:0] mem_q [MEM_WORDS];

    // Two response stages with s2 driving the output
    logic       s1_valid_q;
    logic       s2_valid_q;
    tcdm_resp_t s1_resp_q;
    tcdm_resp_t s2_resp_q;

    logic       advance;
    logic       accept;
    tcdm_resp_t new_resp;

    // Pipeline moves unless the output stage is stuck
    assign advance     = !s2_valid_q || resp_ready_i;
    assign req_ready_o = advance;
    assign accept      = req_valid_i && advance;

    always_comb begin
        new_resp.rdata = req_i.write ? '0 : mem_q[req_i.addr];
        new_resp.write = req_i.write;
        new_resp.id    = req_i.id;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem_q[a] <= '0;
            end
        end else if (accept && req_i.write) begin
            mem_q[req_i.addr] <= req_i.wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response pipeline
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (advance) begin
            s1_valid_q <= accept;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            s1_resp_q <= new_resp;
            s2_resp_q <= s1_resp_q;
        end
    end

    assign resp_o       = s2_resp_q;
    assign resp_valid_o = s2_valid_q;

endmodule

`default_nettype wire

// File: logic/tcdm_subsystem.sv
`default_nettype none
`timescale 1ns/100ps

module tcdm_subsystem import tcdm_pkg::*, remap_pkg::*; (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire tcdm_req_t  [NUM_MASTERS-1:0] req_i,
    input  wire logic       [NUM_MASTERS-1:0] req_valid_i,
    output logic            [NUM_MASTERS-1:0] req_ready_o,
    output tcdm_resp_t      [NUM_MASTERS-1:0] resp_o,
    output logic            [NUM_MASTERS-1:0] resp_valid_o,
    input  wire logic       [NUM_MASTERS-1:0] resp_ready_i
);

    // Remapper to bank channels
    tcdm_req_t  bank_req;
    logic       bank_req_valid;
    logic       bank_req_ready;
    tcdm_resp_t bank_resp;
    logic       bank_resp_valid;
    logic       bank_resp_ready;

    tcdm_id_remapper i_remapper (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .req_i             (req_i),
        .req_valid_i       (req_valid_i),
        .req_ready_o       (req_ready_o),
        .resp_o            (resp_o),
        .resp_valid_o      (resp_valid_o),
        .resp_ready_i      (resp_ready_i),
        .bank_req_o        (bank_req),
        .bank_req_valid_o  (bank_req_valid),
        .bank_req_ready_i  (bank_req_ready),
        .bank_resp_i       (bank_resp),
        .bank_resp_valid_i (bank_resp_valid),
        .bank_resp_ready_o (bank_resp_ready)
    );

    tcdm_bank i_bank (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (bank_req),
        .req_valid_i  (bank_req_valid),
        .req_ready_o  (bank_req_ready),
        .resp_o       (bank_resp),
        .resp_valid_o (bank_resp_valid),
        .resp_ready_i (bank_resp_ready)
    );

endmodule

`default_nettype wire

// File: test/tb_tcdm_model.svh
`ifndef TB_TCDM_MODEL_SVH
`define TB_TCDM_MODEL_SVH

// Reference copy of the bank contents, zero like the bank after reset
logic [DATA_W-1:0] ref_mem [MEM_WORDS] = '{default: '0};

// Galois LFSR with x^16 + x^14 + x^13 + x^11 + 1
localparam logic [15:0] LFSR_SEED = 16'd37764;
localparam logic [15:0] LFSR_TAPS = 16'hB400;
logic [15:0] lfsr_q = LFSR_SEED;

task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "Run stopped after an error");
endtask

// Expected response of one accepted request, applied in acceptance order
function automatic tcdm_resp_t ref_access(input tcdm_req_t req_in);
    tcdm_resp_t r;
    r.write = req_in.write;
    r.id    = req_in.id;
    if (req_in.write) begin
        r.rdata               = '0;
        ref_mem[req_in.addr] = req_in.wdata;
    end else begin
        r.rdata = ref_mem[req_in.addr];
    end
    return r;
endfunction

// One LFSR step per bit, first bit taken ends up as the MSB
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r      = {r[30:0], lfsr_q[0]};
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return r;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp_val);
    if (got !== exp_val) begin
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp_val);
        stop_run();
    end
endtask

`endif

// File: test/tb_tcdm_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_tcdm_subsystem import tcdm_pkg::*, remap_pkg::*; ();

    localparam int unsigned SCRIPT_REQS = 12;
    localparam int unsigned RAND_REQS   = 20;
    localparam int unsigned HOLD_REQS   = 3;
    localparam int unsigned TOTAL_REQS  =
        SCRIPT_REQS + NUM_MASTERS * (2 * RAND_REQS + HOLD_REQS);
    localparam int unsigned CYCLE_LIMIT = 3 * TOTAL_REQS + 200;

    logic                         clk;
    logic                         rst_n;
    tcdm_req_t  [NUM_MASTERS-1:0] req        = '0;
    logic       [NUM_MASTERS-1:0] req_valid  = '0;
    logic       [NUM_MASTERS-1:0] req_ready;
    tcdm_resp_t [NUM_MASTERS-1:0] resp;
    logic       [NUM_MASTERS-1:0] resp_valid;
    logic       [NUM_MASTERS-1:0] resp_ready = '0;

    // Back-pressure mode 0 all ready, 1 random ready, 2 all blocked
    logic [1:0]  bp_mode   = 2'd0;
    bit          script_go = 1'b0;
    int unsigned rand_target [NUM_MASTERS] = '{default: 0};

    int unsigned script_pos = 0;
    int unsigned issued_rand [NUM_MASTERS] = '{default: 0};

    // Expected responses per master in issue order
    tcdm_resp_t  exp_q [NUM_MASTERS][$];
    int          grant_win [$];
    int unsigned accepts_since_resp = 0;
    int unsigned cycle_cnt = 0;

    `include "tb_tcdm_model.svh"

    tcdm_subsystem UUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_i        (req),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .resp_o       (resp),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Master 0 writes four words, reads them back plus one untouched word
    function automatic tcdm_req_t script_entry(input int unsigned n);
        tcdm_req_t r;
        r.id    = 4'h9;
        r.wdata = '0;
        r.write = 1'b0;
        if (n < 4) begin
            r.write = 1'b1;
            r.addr  = 8'h10 + ADDR_W'(n);
            r.wdata = 32'h1000_0000 + 32'(n) * 32'h0011_0011;
        end else if (n < 9) begin
            r.addr = 8'h10 + ADDR_W'(n - 4);
        end else if (n == 9) begin
            r.write = 1'b1;
            r.addr  = 8'h11;
            r.wdata = 32'hDEAD_BEEF;
        end else begin
            r.addr = (n == 10) ? 8'h11 : 8'h10;
        end
        return r;
    endfunction

    // Addresses stay within 16 words so reads often hit earlier writes
    function automatic tcdm_req_t random_req();
        tcdm_req_t r;
        r.addr  = {4'h3, 4'(rand_bits(4))};
        r.write = 1'(rand_bits(1));
        r.wdata = rand_bits(32);
        r.id    = meta_id_t'(rand_bits(4));
        return r;
    endfunction

    always @(posedge clk) begin
        if (rst_n) begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                // Next request only once the current one is taken
                if (!req_valid[m] || req_ready[m]) begin
                    if (m == 0 && script_go && script_pos < SCRIPT_REQS) begin
                        req[m]       <= script_entry(script_pos);
                        req_valid[m] <= 1'b1;
                        script_pos++;
                    end else if (issued_rand[m] < rand_target[m]) begin
                        req[m]       <= random_req();
                        req_valid[m] <= 1'b1;
                        issued_rand[m]++;
                    end else begin
                        req_valid[m] <= 1'b0;
                    end
                end
            end
            case (bp_mode)
                2'd0:    resp_ready <= '1;
                2'd1:    resp_ready <= NUM_MASTERS'(rand_bits(NUM_MASTERS));
                default: resp_ready <= '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    // Under full contention the last NUM_MASTERS grants cover every master
    task automatic check_rotation();
        logic [NUM_MASTERS-1:0] seen;
        seen = '0;
        foreach (grant_win[k]) begin
            seen[grant_win[k]] = 1'b1;
        end
        check_value("grant rotation", 32'(seen), 32'((1 << NUM_MASTERS) - 1));
    endtask

    always @(posedge clk) begin
        tcdm_resp_t expected;
        if (rst_n) begin
            if ($countones(resp_valid) > 1) begin
                $display("More than one master saw a valid response in one cycle");
                stop_run();
            end
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (resp_valid[m] && resp_ready[m]) begin
                    accepts_since_resp = 0;
                    if (exp_q[m].size() == 0) begin
                        $display("Master %0d received a response it never asked for", m);
                        stop_run();
                    end else begin
                        expected = exp_q[m].pop_front();
                        check_value($sformatf("resp_o[%0d].rdata", m),
                                    resp[m].rdata, expected.rdata);
                        check_value($sformatf("resp_o[%0d].write", m),
                                    32'(resp[m].write), 32'(expected.write));
                        check_value($sformatf("resp_o[%0d].id", m),
                                    32'(resp[m].id), 32'(expected.id));
                    end
                end
            end
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (req_valid[m] && req_ready[m]) begin
                    exp_q[m].push_back(ref_access(req[m]));
                    accepts_since_resp++;
                    if (&req_valid) begin
                        grant_win.push_back(m);
                        if (grant_win.size() > NUM_MASTERS) begin
                            void'(grant_win.pop_front());
                        end
                        if (grant_win.size() == NUM_MASTERS) begin
                            check_rotation();
                        end
                    end else begin
                        grant_win.delete();
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, traffic did not drain", cycle_cnt);
            stop_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    function automatic bit all_idle();
        bit idle;
        idle = (req_valid == '0) && (!script_go || script_pos >= SCRIPT_REQS);
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (issued_rand[m] < rand_target[m] || exp_q[m].size() != 0) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (!all_idle());
    endtask

    task automatic raise_targets(input int unsigned n);
        for (int m = 0; m < NUM_MASTERS; m++) begin
            rand_target[m] += n;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        repeat (5) begin
            @(negedge clk);
            check_value("resp_valid_o", 32'(resp_valid), 32'h0);
        end

        script_go = 1'b1;
        wait_idle();

        // All masters busy without back-pressure
        raise_targets(RAND_REQS);
        wait_idle();

        bp_mode = 2'd1;
        raise_targets(RAND_REQS);
        wait_idle();

        // With every response blocked acceptance is bounded by the slot count
        bp_mode = 2'd2;
        raise_targets(HOLD_REQS);
        repeat (16) @(negedge clk);
        if (accepts_since_resp == 0) begin
            $display("No request was accepted while responses were blocked");
            stop_run();
        end else if (accepts_since_resp > SLOT_DEPTH) begin
            $display("%0d requests accepted with only %0d slots and responses blocked",
                     accepts_since_resp, SLOT_DEPTH);
            stop_run();
        end
        bp_mode = 2'd0;
        wait_idle();

        // A duplicated response would surface within the bank latency
        repeat (4) @(negedge clk);
        if (resp_valid != '0) begin
            $display("A response was still valid after every expected one arrived");
            stop_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+test
logic/tcdm_pkg.sv
logic/remap_pkg.sv
logic/tcdm_rr_arbiter.sv
logic/tcdm_slot_table.sv
logic/tcdm_id_remapper.sv
logic/tcdm_bank.sv
logic/tcdm_subsystem.sv
test/tb_tcdm_subsystem.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -f list.f \
    --top-module tb_tcdm_subsystem -o tb_tcdm_subsystem &&
./obj_dir/tb_tcdm_subsystem || { echo "Simulation did not complete successfully"; exit 1; }
